//--- rvc_pkg.sv
package rvc_pkg;

    localparam int reg_idx_w = 5;

    // ALU operations, PASSB forwards operand B unchanged
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        PASSB
    } alu_op_e;

    typedef enum logic [1:0] {
        NONE,       // no control transfer
        JUMP,       // pc + offset
        JUMP_REG,   // rs1 value
        BRANCH      // pc + offset when condition holds
    } target_e;

    // expanded form of one compressed instruction
    typedef struct packed {
        logic [reg_idx_w-1:0] rs1;
        logic [reg_idx_w-1:0] rs2;
        logic [reg_idx_w-1:0] rd;
        alu_op_e              alu_op;
        logic                 use_imm;         // operand b from imm
        logic [31:0]          imm;
        logic [31:0]          offset;          // jump or branch displacement
        target_e              target;
        logic                 branch_on_zero;  // beqz when set, bnez otherwise
        logic                 link;            // rd gets pc + 2
        logic                 wr_en;
        logic                 illegal;
        logic [31:0]          pc;
    } dec_ctrl_t;

    // execute stage result, held in the last stage register
    typedef struct packed {
        logic [reg_idx_w-1:0] rd;
        logic                 wr_en;
        logic [31:0]          data;
        logic                 redirect;
        logic [31:0]          redirect_pc;
        logic                 illegal;
        logic [31:0]          pc;
    } exe_res_t;

endpackage

//--- rvc_decoder.sv
`timescale 1ns/100ps

module rvc_decoder (
    input  logic [15:0]        i_inst,
    input  logic [31:0]        i_pc,
    output rvc_pkg::dec_ctrl_t o_ctrl
);

    logic [1:0]                    quad;
    logic [2:0]                    funct3;
    logic                          funct4;
    logic [1:0]                    funct2;
    logic [1:0]                    funct2_lo;
    logic [rvc_pkg::reg_idx_w-1:0] rd_full;   // CR/CI rd, also rs1
    logic [rvc_pkg::reg_idx_w-1:0] rs2_full;
    logic [rvc_pkg::reg_idx_w-1:0] rs1_p;     // abbreviated, x8..x15
    logic [rvc_pkg::reg_idx_w-1:0] rs2_p;
    logic                          sign;

    logic [31:0] imm_ci;
    logic [31:0] imm_shamt;
    logic [31:0] imm_lui;
    logic [31:0] imm_16sp;
    logic [31:0] imm_4spn;
    logic [31:0] off_j;
    logic [31:0] off_b;

    assign quad      = i_inst[1:0];
    assign funct3    = i_inst[15:13];
    assign funct4    = i_inst[12];
    assign funct2    = i_inst[11:10];
    assign funct2_lo = i_inst[6:5];
    assign rd_full   = i_inst[11:7];
    assign rs2_full  = i_inst[6:2];
    assign rs1_p     = {2'b01, i_inst[9:7]};
    assign rs2_p     = {2'b01, i_inst[4:2]};
    assign sign      = i_inst[12];

    assign imm_ci    = {{26{sign}}, i_inst[12], i_inst[6:2]};
    assign imm_shamt = {26'b0, i_inst[12], i_inst[6:2]};
    assign imm_lui   = {{14{sign}}, i_inst[12], i_inst[6:2], 12'b0};
    // nzimm[9|4|6|8:7|5], scaled by 16
    assign imm_16sp  = {{22{sign}}, i_inst[12], i_inst[4:3], i_inst[5], i_inst[2],
                        i_inst[6], 4'b0};
    // nzuimm[5:4|9:6|2|3], zero extended
    assign imm_4spn  = {22'b0, i_inst[10:7], i_inst[12:11], i_inst[5], i_inst[6], 2'b0};
    assign off_j     = {{20{sign}}, i_inst[12], i_inst[8], i_inst[10:9], i_inst[6],
                        i_inst[7], i_inst[2], i_inst[11], i_inst[5:3], 1'b0};
    assign off_b     = {{23{sign}}, i_inst[12], i_inst[6:5], i_inst[2], i_inst[11:10],
                        i_inst[4:3], 1'b0};

    always_comb begin
        o_ctrl         = '0;
        o_ctrl.pc      = i_pc;
        o_ctrl.offset  = off_j;
        o_ctrl.alu_op  = rvc_pkg::ADD;
        o_ctrl.use_imm = 1'b1;
        o_ctrl.imm     = imm_ci;
        case (quad)
            2'd0: begin
                if (funct3 == 3'd0) begin           // ADDI4SPN
                    o_ctrl.rd    = rs2_p;
                    o_ctrl.rs1   = 5'd2;
                    o_ctrl.imm   = imm_4spn;
                    o_ctrl.wr_en = 1'b1;
                end else begin
                    o_ctrl.illegal = 1'b1;          // C.LW, C.SW, fp slots
                end
            end
            2'd1: begin
                case (funct3)
                    3'd0, 3'd2: begin               // ADDI, LI
                        o_ctrl.rd    = rd_full;
                        o_ctrl.rs1   = (funct3 == 3'd0) ? rd_full : 5'd0;
                        o_ctrl.wr_en = 1'b1;
                        if (funct3 == 3'd2) o_ctrl.alu_op = rvc_pkg::PASSB;
                    end
                    3'd1: begin                     // JAL, link into x1
                        o_ctrl.rd     = 5'd1;
                        o_ctrl.target = rvc_pkg::JUMP;
                        o_ctrl.link   = 1'b1;
                        o_ctrl.wr_en  = 1'b1;
                    end
                    3'd3: begin
                        o_ctrl.rd    = rd_full;
                        o_ctrl.wr_en = 1'b1;
                        if (rd_full == 5'd2) begin  // ADDI16SP
                            o_ctrl.rs1 = 5'd2;
                            o_ctrl.imm = imm_16sp;
                        end else begin              // LUI
                            o_ctrl.alu_op = rvc_pkg::PASSB;
                            o_ctrl.imm    = imm_lui;
                        end
                    end
                    3'd4: begin
                        o_ctrl.rd    = rs1_p;
                        o_ctrl.rs1   = rs1_p;
                        o_ctrl.wr_en = 1'b1;
                        case (funct2)
                            2'd0, 2'd1: begin       // SRLI, SRAI
                                o_ctrl.imm     = imm_shamt;
                                o_ctrl.alu_op  = funct2[0] ? rvc_pkg::SRA : rvc_pkg::SRL;
                                o_ctrl.illegal = i_inst[12];  // shamt[5] reserved on rv32
                            end
                            2'd2: o_ctrl.alu_op = rvc_pkg::AND;   // ANDI
                            default: begin
                                o_ctrl.rs2     = rs2_p;
                                o_ctrl.use_imm = 1'b0;
                                o_ctrl.illegal = funct4;  // rv64 only row
                                case (funct2_lo)
                                    2'd0:    o_ctrl.alu_op = rvc_pkg::SUB;
                                    2'd1:    o_ctrl.alu_op = rvc_pkg::XOR;
                                    2'd2:    o_ctrl.alu_op = rvc_pkg::OR;
                                    default: o_ctrl.alu_op = rvc_pkg::AND;
                                endcase
                            end
                        endcase
                    end
                    3'd5: o_ctrl.target = rvc_pkg::JUMP;   // J
                    default: begin                  // BEQZ, BNEZ
                        o_ctrl.rs1            = rs1_p;
                        o_ctrl.target         = rvc_pkg::BRANCH;
                        o_ctrl.offset         = off_b;
                        o_ctrl.branch_on_zero = ~funct3[0];
                    end
                endcase
            end
            2'd2: begin
                case (funct3)
                    3'd0: begin                     // SLLI
                        o_ctrl.rd      = rd_full;
                        o_ctrl.rs1     = rd_full;
                        o_ctrl.imm     = imm_shamt;
                        o_ctrl.alu_op  = rvc_pkg::SLL;
                        o_ctrl.wr_en   = 1'b1;
                        o_ctrl.illegal = i_inst[12];
                    end
                    3'd4: begin
                        if (rs2_full == 5'd0) begin
                            o_ctrl.illegal = (rd_full == 5'd0);   // EBREAK, JR x0
                            o_ctrl.rs1     = rd_full;
                            o_ctrl.target  = rvc_pkg::JUMP_REG;
                            o_ctrl.rd      = funct4 ? 5'd1 : 5'd0;  // JALR links
                            o_ctrl.link    = funct4;
                            o_ctrl.wr_en   = funct4;
                        end else begin              // ADD, MV
                            o_ctrl.rd      = rd_full;
                            o_ctrl.rs1     = funct4 ? rd_full : 5'd0;
                            o_ctrl.rs2     = rs2_full;
                            o_ctrl.use_imm = 1'b0;
                            o_ctrl.alu_op  = funct4 ? rvc_pkg::ADD : rvc_pkg::PASSB;
                            o_ctrl.wr_en   = 1'b1;
                        end
                    end
                    default: o_ctrl.illegal = 1'b1; // LWSP, SWSP, fp slots
                endcase
            end
            default: o_ctrl.illegal = 1'b1;         // 32-bit encoding
        endcase
        o_ctrl.wr_en = o_ctrl.wr_en && !o_ctrl.illegal && (i_inst != 16'h0000);
    end

endmodule

//--- rvc_stage_reg.sv
`timescale 1ns/100ps

module rvc_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_valid,
    input  payload_t i_data,
    output logic     o_valid,
    output payload_t o_data
);

    // strobe moves one stage per clock
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        o_data <= i_data;  // payload is don't care while invalid
    end

endmodule

//--- rvc_regfile.sv
`timescale 1ns/100ps

module rvc_regfile #(
    parameter logic [31:0] sp_reset = 32'h0000_1000
) (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic [rvc_pkg::reg_idx_w-1:0] i_rs1,
    input  logic [rvc_pkg::reg_idx_w-1:0] i_rs2,
    output logic [31:0]                   o_rs1_data,
    output logic [31:0]                   o_rs2_data,
    input  logic                          i_we,
    input  logic [rvc_pkg::reg_idx_w-1:0] i_rd,
    input  logic [31:0]                   i_wd
);

    logic [31:0] regs [32];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= (k == 2) ? sp_reset : 32'h0;  // sp starts at top of stack
            end
        end else if (i_we && i_rd != '0) begin
            regs[i_rd] <= i_wd;
        end
    end

    // async reads, x0 hard-wired
    assign o_rs1_data = (i_rs1 == '0) ? 32'h0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? 32'h0 : regs[i_rs2];

endmodule

//--- rvc_execute.sv
`timescale 1ns/100ps

module rvc_execute (
    input  logic                          i_valid,
    input  rvc_pkg::dec_ctrl_t            i_ctrl,
    output logic [rvc_pkg::reg_idx_w-1:0] o_rs1,
    output logic [rvc_pkg::reg_idx_w-1:0] o_rs2,
    input  logic [31:0]                   i_rs1_data,
    input  logic [31:0]                   i_rs2_data,
    input  logic                          i_fwd_valid,
    input  logic [rvc_pkg::reg_idx_w-1:0] i_fwd_rd,
    input  logic [31:0]                   i_fwd_data,
    output rvc_pkg::exe_res_t             o_res
);

    logic [31:0]       rs1_val;
    logic [31:0]       rs2_val;
    logic [31:0]       op_b;
    logic [31:0]       alu_out;
    logic [31:0]       target_pc;
    logic              taken;
    rvc_pkg::exe_res_t res;

    assign o_rs1 = i_ctrl.rs1;
    assign o_rs2 = i_ctrl.rs2;

    // result one place ahead is not in the register file yet
    assign rs1_val = (i_fwd_valid && i_fwd_rd == i_ctrl.rs1) ? i_fwd_data : i_rs1_data;
    assign rs2_val = (i_fwd_valid && i_fwd_rd == i_ctrl.rs2) ? i_fwd_data : i_rs2_data;
    assign op_b    = i_ctrl.use_imm ? i_ctrl.imm : rs2_val;

    always_comb begin
        case (i_ctrl.alu_op)
            rvc_pkg::SUB:   alu_out = rs1_val - op_b;
            rvc_pkg::AND:   alu_out = rs1_val & op_b;
            rvc_pkg::OR:    alu_out = rs1_val | op_b;
            rvc_pkg::XOR:   alu_out = rs1_val ^ op_b;
            rvc_pkg::SLL:   alu_out = rs1_val << op_b[4:0];
            rvc_pkg::SRL:   alu_out = rs1_val >> op_b[4:0];
            rvc_pkg::SRA:   alu_out = $unsigned($signed(rs1_val) >>> op_b[4:0]);
            rvc_pkg::PASSB: alu_out = op_b;
            default:        alu_out = rs1_val + op_b;
        endcase
    end

    always_comb begin
        target_pc = i_ctrl.pc + i_ctrl.offset;
        taken     = 1'b0;
        case (i_ctrl.target)
            rvc_pkg::JUMP:     taken = 1'b1;
            rvc_pkg::JUMP_REG: begin
                taken     = 1'b1;
                target_pc = rs1_val;
            end
            rvc_pkg::BRANCH:   taken = ((rs1_val == 32'h0) == i_ctrl.branch_on_zero);
            default:           taken = 1'b0;
        endcase
    end

    always_comb begin
        res.rd          = i_ctrl.rd;
        res.wr_en       = i_ctrl.wr_en;
        res.data        = i_ctrl.link ? i_ctrl.pc + 32'd2 : alu_out;
        res.redirect    = taken && !i_ctrl.illegal;
        res.redirect_pc = {target_pc[31:1], 1'b0};  // halfword aligned
        res.illegal     = i_ctrl.illegal;
        res.pc          = i_ctrl.pc;
        o_res           = i_valid ? res : '0;
    end

endmodule

//--- rvc_writeback.sv
`timescale 1ns/100ps

module rvc_writeback (
    input  logic                          i_valid,
    input  rvc_pkg::exe_res_t             i_res,
    output logic                          o_rf_we,
    output logic [rvc_pkg::reg_idx_w-1:0] o_rf_rd,
    output logic [31:0]                   o_rf_wd,
    output logic                          o_wb_valid,
    output logic [rvc_pkg::reg_idx_w-1:0] o_wb_rd,
    output logic [31:0]                   o_wb_data,
    output logic                          o_redirect_valid,
    output logic [31:0]                   o_redirect_pc,
    output logic                          o_illegal
);

    logic do_wr;

    // no write for x0, disabled writes and illegal words
    assign do_wr = i_valid && i_res.wr_en && !i_res.illegal && (i_res.rd != '0);

    assign o_rf_we    = do_wr;
    assign o_rf_rd    = i_res.rd;
    assign o_rf_wd    = i_res.data;
    assign o_wb_valid = do_wr;
    assign o_wb_rd    = i_res.rd;
    assign o_wb_data  = i_res.data;

    assign o_redirect_valid = i_valid && i_res.redirect;
    assign o_redirect_pc    = i_res.redirect_pc;
    assign o_illegal        = i_valid && i_res.illegal;

endmodule

//--- rvc_core.sv
`timescale 1ns/100ps

module rvc_core #(
    parameter logic [31:0] sp_reset = 32'h0000_1000
) (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_inst_valid,
    input  logic [15:0]                   i_inst,
    input  logic [31:0]                   i_pc,
    output logic                          o_wb_valid,
    output logic [rvc_pkg::reg_idx_w-1:0] o_wb_rd,
    output logic [31:0]                   o_wb_data,
    output logic                          o_redirect_valid,
    output logic [31:0]                   o_redirect_pc,
    output logic                          o_illegal
);

    rvc_pkg::dec_ctrl_t            dec_ctrl;
    rvc_pkg::dec_ctrl_t            ex_ctrl;
    rvc_pkg::exe_res_t             ex_res;
    rvc_pkg::exe_res_t             wb_res;
    logic                          ex_valid;
    logic                          wb_valid;
    logic [rvc_pkg::reg_idx_w-1:0] rs1;
    logic [rvc_pkg::reg_idx_w-1:0] rs2;
    logic [31:0]                   rs1_data;
    logic [31:0]                   rs2_data;
    logic                          rf_we;     // doubles as forward valid
    logic [rvc_pkg::reg_idx_w-1:0] rf_rd;
    logic [31:0]                   rf_wd;

    rvc_decoder i_decoder (.i_inst(i_inst), .i_pc(i_pc), .o_ctrl(dec_ctrl));

    rvc_stage_reg #(.payload_t(rvc_pkg::dec_ctrl_t)) i_stage_ex (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_valid(i_inst_valid), .i_data(dec_ctrl),
        .o_valid(ex_valid), .o_data(ex_ctrl)
    );

    rvc_execute i_execute (
        .i_valid(ex_valid), .i_ctrl(ex_ctrl), .o_rs1(rs1), .o_rs2(rs2),
        .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
        .i_fwd_valid(rf_we), .i_fwd_rd(rf_rd), .i_fwd_data(rf_wd), .o_res(ex_res)
    );

    rvc_stage_reg #(.payload_t(rvc_pkg::exe_res_t)) i_stage_wb (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_valid(ex_valid), .i_data(ex_res),
        .o_valid(wb_valid), .o_data(wb_res)
    );

    rvc_regfile #(.sp_reset(sp_reset)) i_regfile (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_rs1(rs1), .i_rs2(rs2),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data),
        .i_we(rf_we), .i_rd(rf_rd), .i_wd(rf_wd)
    );

    rvc_writeback i_writeback (
        .i_valid(wb_valid), .i_res(wb_res),
        .o_rf_we(rf_we), .o_rf_rd(rf_rd), .o_rf_wd(rf_wd),
        .o_wb_valid(o_wb_valid), .o_wb_rd(o_wb_rd), .o_wb_data(o_wb_data),
        .o_redirect_valid(o_redirect_valid), .o_redirect_pc(o_redirect_pc),
        .o_illegal(o_illegal)
    );

endmodule

//--- rvc_core_assert.sv
`timescale 1ns/100ps

module rvc_core_assert (
    input logic        i_clk,
    input logic        i_rst_n,
    input logic        i_wb_valid,
    input logic [4:0]  i_wb_rd,
    input logic        i_redirect_valid,
    input logic [31:0] i_redirect_pc,
    input logic        i_illegal
);

    int   fail_cnt = 0;
    logic any_strobe;

    assign any_strobe = i_wb_valid || i_redirect_valid || i_illegal;

    // quiet in reset and the cycle after release
    a_reset_quiet: assert property (@(posedge i_clk) !i_rst_n |-> !any_strobe)
        else begin $error("output strobe high during reset"); fail_cnt++; end
    a_release_quiet: assert property (@(posedge i_clk)
        $rose(i_rst_n) |-> !any_strobe ##1 !any_strobe)
        else begin $error("output strobe high right after reset"); fail_cnt++; end

    a_no_x0_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wb_valid |-> i_wb_rd != 5'd0)
        else begin $error("write-back strobe for x0"); fail_cnt++; end

    a_illegal_no_wb: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_illegal && i_wb_valid))
        else begin $error("illegal word wrote back"); fail_cnt++; end

    a_pc_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_redirect_pc[0] == 1'b0)
        else begin $error("redirect pc odd"); fail_cnt++; end

endmodule

bind rvc_core rvc_core_assert i_assert (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_wb_valid(o_wb_valid), .i_wb_rd(o_wb_rd),
    .i_redirect_valid(o_redirect_valid), .i_redirect_pc(o_redirect_pc),
    .i_illegal(o_illegal)
);

//--- tb_rvc_core.sv
`timescale 1ns/100ps

module tb_rvc_core;

    localparam logic [31:0] sp_reset = 32'h0000_3ff0;
    localparam int          n_instr  = 69;   // 16 + 33 + 3 + 4 + 6 + 7

    typedef struct packed {
        logic [2:0]  tid;
        logic        wb;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        redir;
        logic [31:0] rpc;
        logic        ill;    // x means either value is accepted
    } exp_t;

    logic        i_clk;
    logic        i_rst_n;
    logic        i_inst_valid;
    logic [15:0] i_inst;
    logic [31:0] i_pc;
    logic        o_wb_valid;
    logic [4:0]  o_wb_rd;
    logic [31:0] o_wb_data;
    logic        o_redirect_valid;
    logic [31:0] o_redirect_pc;
    logic        o_illegal;

    exp_t        exp_q[$];
    logic [31:0] shadow [32];   // reference register file
    logic [1:0]  vld_d;         // issue strobe delayed to the output slot
    logic [2:0]  cur_tid;
    logic [31:0] pc;
    integer      seed = 32'hd0f5d0b9;
    int          errors = 0;
    int          n_checks = 0;
    int          test_errs = 0;
    int          test_checks = 0;
    int          chk_tid = 0;
    int          sva_fails;
    logic [31:0] v;
    logic [5:0]  a;
    logic [4:0]  s1, s2, s3;
    logic [11:0] off;
    logic [8:0]  ob;
    logic [9:0]  u, n;

    rvc_core #(.sp_reset(sp_reset)) i_rvc_core (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_inst_valid(i_inst_valid), .i_inst(i_inst),
        .i_pc(i_pc), .o_wb_valid(o_wb_valid), .o_wb_rd(o_wb_rd), .o_wb_data(o_wb_data),
        .o_redirect_valid(o_redirect_valid), .o_redirect_pc(o_redirect_pc),
        .o_illegal(o_illegal)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    initial begin
        #((n_instr + 20) * 40);
        $display("timeout: outputs did not drain before the time limit");
        $display("TEST FAIL");
        $finish;
    end

    // standard rvc encodings, built from fields
    function automatic logic [15:0] ci(input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [5:0] imm, input logic [1:0] q);
        return {f3, imm[5], rd, imm[4:0], q};
    endfunction

    function automatic logic [15:0] cb_imm(input logic [1:0] f2, input logic [2:0] rdp,
                                           input logic [5:0] imm);
        return {3'b100, imm[5], f2, rdp, imm[4:0], 2'b01};
    endfunction

    function automatic logic [15:0] ca(input logic [1:0] op, input logic [2:0] rdp,
                                       input logic [2:0] rs2p);
        return {6'b100011, rdp, op, rs2p, 2'b01};
    endfunction

    function automatic logic [15:0] cr(input logic f4, input logic [4:0] rd,
                                       input logic [4:0] rs2);
        return {3'b100, f4, rd, rs2, 2'b10};
    endfunction

    function automatic logic [15:0] cj(input logic [2:0] f3, input logic [11:0] o);
        return {f3, o[11], o[4], o[9:8], o[10], o[6], o[7], o[3:1], o[5], 2'b01};
    endfunction

    function automatic logic [15:0] cbr(input logic [2:0] f3, input logic [2:0] rsp,
                                        input logic [8:0] o);
        return {f3, o[8], o[4:3], rsp, o[7:6], o[2:1], o[5], 2'b01};
    endfunction

    function automatic logic [15:0] sp16(input logic [9:0] m);
        return {3'b011, m[9], 5'd2, m[4], m[6], m[8:7], m[5], 2'b01};
    endfunction

    function automatic logic [15:0] spn4(input logic [9:0] m, input logic [2:0] rdp);
        return {3'b000, m[5:4], m[9:6], m[2], m[3], rdp, 2'b00};
    endfunction

    function automatic logic [31:0] sx6(input logic [5:0] x);
        return {{26{x[5]}}, x};
    endfunction

    function automatic string test_name(input int t);
        case (t)
            1:       return "li and lui";
            2:       return "alu chain";
            3:       return "stack pointer";
            4:       return "jumps";
            5:       return "branches";
            default: return "illegal words";
        endcase
    endfunction

    task automatic flag(input string msg);
        errors++;
        test_errs++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    task automatic report_test(input int t);
        $display("test %0d (%s): %0d checked, %0d errors", t, test_name(t), test_checks,
                 test_errs);
        test_checks = 0;
        test_errs   = 0;
    endtask

    // model the instruction, then drive it on the falling edge
    task automatic issue(input logic [15:0] inst, input logic wb, input logic [4:0] rd,
                         input logic [31:0] val, input logic redir, input logic [31:0] rpc,
                         input logic ill);
        exp_t e;
        e = {cur_tid, wb, rd, val, redir, rpc, ill};
        if (wb) shadow[rd] = val;
        @(negedge i_clk);
        i_inst_valid = 1'b1;
        i_inst       = inst;
        i_pc         = pc;
        exp_q.push_back(e);
        pc = pc + 32'd2;
    endtask

    task automatic wr(input logic [15:0] inst, input logic [4:0] rd, input logic [31:0] val);
        issue(inst, 1'b1, rd, val, 1'b0, 32'h0, 1'b0);
    endtask

    task automatic ctl(input logic [15:0] inst, input logic redir, input logic [31:0] rpc,
                       input logic ill);
        issue(inst, 1'b0, 5'd0, 32'h0, redir, rpc, ill);
    endtask

    task automatic check_one();
        exp_t e;
        if (exp_q.size() == 0) begin
            flag("output slot reached with nothing queued in the reference model");
            return;
        end
        e = exp_q.pop_front();
        if (e.tid != chk_tid) begin
            if (chk_tid != 0) report_test(chk_tid);
            chk_tid = e.tid;
        end
        test_checks++;
        n_checks++;
        assert (o_wb_valid == e.wb)
            else flag($sformatf("o_wb_valid %0b, expected %0b", o_wb_valid, e.wb));
        if (e.wb) assert (o_wb_rd == e.rd && o_wb_data == e.data)
            else flag($sformatf("x%0d = %h, expected x%0d = %h", o_wb_rd, o_wb_data,
                                e.rd, e.data));
        assert (o_redirect_valid == e.redir)
            else flag($sformatf("o_redirect_valid %0b, expected %0b", o_redirect_valid,
                                e.redir));
        if (e.redir) assert (o_redirect_pc == e.rpc)
            else flag($sformatf("redirect to %h, expected %h", o_redirect_pc, e.rpc));
        assert (e.ill === 1'bx || o_illegal == e.ill)
            else flag($sformatf("o_illegal %0b, expected %0b", o_illegal, e.ill));
    endtask

    always @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) vld_d <= '0;
        else          vld_d <= {vld_d[0], i_inst_valid};
    end

    // outputs are stable at the falling edge
    always @(negedge i_clk) begin
        if (i_rst_n) begin
            if (vld_d[1]) check_one();
            else assert (!o_wb_valid && !o_redirect_valid && !o_illegal)
                else flag("output strobe high with no instruction in flight");
        end
    end

    initial begin
        i_rst_n      = 1'b0;
        i_inst_valid = 1'b0;
        i_inst       = 16'h0;
        i_pc         = 32'h0;
        pc           = 32'h0000_0100;
        for (int k = 0; k < 32; k++) shadow[k] = (k == 2) ? sp_reset : 32'h0;
        repeat (2) @(negedge i_clk);
        i_rst_n = 1'b1;

        cur_tid = 3'd1;
        for (int r = 8; r < 16; r++) begin
            v = $random(seed);
            a = v[11:6] | 6'd1;   // lui needs a nonzero immediate
            wr(ci(3'b011, r[4:0], a, 2'b01), r[4:0], sx6(a) << 12);
            wr(ci(3'b010, r[4:0], v[5:0], 2'b01), r[4:0], sx6(v[5:0]));
        end

        cur_tid = 3'd2;   // x8 and x9 alternate, so sources sit one or two places back
        for (int k = 0; k < 3; k++) begin
            v  = $random(seed);
            s1 = v[16:12] | 5'd1;
            s2 = v[21:17] | 5'd1;
            s3 = v[26:22] | 5'd1;
            wr(ci(3'b000, 5'd8, v[5:0], 2'b01), 5'd8, shadow[8] + sx6(v[5:0]));
            wr(cb_imm(2'b10, 3'd1, v[11:6]), 5'd9, shadow[9] & sx6(v[11:6]));
            wr(cb_imm(2'b00, 3'd0, {1'b0, s1}), 5'd8, shadow[8] >> s1);
            wr(cb_imm(2'b01, 3'd1, {1'b0, s2}), 5'd9, $signed(shadow[9]) >>> s2);
            wr(ci(3'b000, 5'd8, {1'b0, s3}, 2'b10), 5'd8, shadow[8] << s3);
            wr(ca(2'b00, 3'd1, 3'd0), 5'd9, shadow[9] - shadow[8]);
            wr(ca(2'b01, 3'd0, 3'd1), 5'd8, shadow[8] ^ shadow[9]);
            wr(ca(2'b10, 3'd1, 3'd0), 5'd9, shadow[9] | shadow[8]);
            wr(ca(2'b11, 3'd0, 3'd1), 5'd8, shadow[8] & shadow[9]);
            wr(cr(1'b0, 5'd10, 5'd8), 5'd10, shadow[8]);
            wr(cr(1'b1, 5'd9, 5'd10), 5'd9, shadow[9] + shadow[10]);
        end

        cur_tid = 3'd3;
        v = $random(seed);
        u = {v[7:0] | 8'd1, 2'b00};
        n = {v[13:8] | 6'd1, 4'b0000};
        wr(spn4(u, 3'd4), 5'd12, shadow[2] + u);
        wr(sp16(n), 5'd2, shadow[2] + {{22{n[9]}}, n});
        u = {v[21:14] | 8'd1, 2'b00};
        wr(spn4(u, 3'd5), 5'd13, shadow[2] + u);

        cur_tid = 3'd4;
        v   = $random(seed);
        off = {v[11:1], 1'b0};
        ctl(cj(3'b101, off), 1'b1, pc + {{20{off[11]}}, off}, 1'b0);
        off = {v[23:13], 1'b0};
        issue(cj(3'b001, off), 1'b1, 5'd1, pc + 32'd2, 1'b1, pc + {{20{off[11]}}, off}, 1'b0);
        ctl(cr(1'b0, 5'd8, 5'd0), 1'b1, shadow[8] & ~32'h1, 1'b0);
        issue(cr(1'b1, 5'd9, 5'd0), 1'b1, 5'd1, pc + 32'd2, 1'b1, shadow[9] & ~32'h1, 1'b0);

        cur_tid = 3'd5;
        v  = $random(seed);
        a  = v[5:0] | 6'd1;
        ob = {v[14:7], 1'b0};
        wr(ci(3'b010, 5'd8, 6'd0, 2'b01), 5'd8, 32'h0);
        wr(ci(3'b010, 5'd9, a, 2'b01), 5'd9, sx6(a));
        ctl(cbr(3'b110, 3'd0, ob), 1'b1, pc + {{23{ob[8]}}, ob}, 1'b0);   // beqz, taken
        ctl(cbr(3'b110, 3'd1, ob), 1'b0, 32'h0, 1'b0);
        ctl(cbr(3'b111, 3'd0, ob), 1'b0, 32'h0, 1'b0);
        ctl(cbr(3'b111, 3'd1, ob), 1'b1, pc + {{23{ob[8]}}, ob}, 1'b0);   // bnez, taken

        cur_tid = 3'd6;
        v = $random(seed);
        ctl({3'b010, v[12:2], 2'b00}, 1'b0, 32'h0, 1'b1);   // c.lw
        ctl({3'b110, v[12:2], 2'b00}, 1'b0, 32'h0, 1'b1);   // c.sw
        ctl({3'b010, v[12:2], 2'b10}, 1'b0, 32'h0, 1'b1);   // c.lwsp
        ctl({3'b110, v[12:2], 2'b10}, 1'b0, 32'h0, 1'b1);   // c.swsp
        ctl(16'h9002, 1'b0, 32'h0, 1'b1);                   // ebreak
        ctl({v[15:2], 2'b11}, 1'b0, 32'h0, 1'b1);
        ctl(16'h0000, 1'b0, 32'h0, 1'bx);

        @(negedge i_clk);
        i_inst_valid = 1'b0;
        while (exp_q.size() != 0) @(negedge i_clk);
        repeat (2) @(negedge i_clk);
        report_test(chk_tid);
        sva_fails = i_rvc_core.i_assert.fail_cnt;
        $display("tests 6, checks %0d, errors %0d, assertion failures %0d", n_checks, errors,
                 sva_fails);
        if (errors == 0 && sva_fails == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- list.f
rvc_pkg.sv
rvc_decoder.sv
rvc_stage_reg.sv
rvc_regfile.sv
rvc_execute.sv
rvc_writeback.sv
rvc_core.sv
rvc_core_assert.sv
tb_rvc_core.sv
